// File: verif/desc_cases.mem
// columns: kind, address, word
// kind 1 preload (byte address, word), 2 start (NDAR, error byte address), 3 end of case
1 00000040 00000001
1 00000048 11111111
1 0000004c 22222222
2 00000040 ffffffff
3 00000000 00000000
1 00000080 00000080
1 00000088 aaaa5555
1 0000008c 0badf00d
2 00000080 ffffffff
3 00000000 00000000
1 00000100 00004080
1 00000104 00000140
1 00000108 33333333
1 00000140 00000083
1 0000014c 44444444
2 00000100 ffffffff
3 00000000 00000000
1 00000200 00004000
1 00000204 00000220
1 00000220 00004080
1 00000224 00000240
1 00000228 55555555
1 00000240 00000081
1 0000024c 66666666
2 00000200 ffffffff
3 00000000 00000000
1 00000300 00004080
1 00000304 00000320
1 00000308 77777777
1 00000320 00000001
2 00000300 00000308
3 00000000 00000000
1 00000380 00000080
1 00000384 88888888
1 0000038c 99999999
2 00000380 ffffffff
3 00000000 00000000

// File: sim.f
+incdir+rtl
rtl/dma_pkg.sv
rtl/burst_addr.sv
rtl/desc_store.sv
rtl/dma_csr.sv
rtl/desc_ctrl.sv
rtl/desc_fetch_top.sv
verif/desc_checker.sv
verif/tb_desc_fetch.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= tb_desc_fetch
FILELIST  ?= sim.f
OBJDIR    ?= obj_dir
PASS_MSG  := === PASS ===

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)

// File: verif/tb_desc_fetch.sv
// ==================================================
// descriptor engine testbench: clock, reset,
// wishbone memory with wait states, case replay
// ==================================================
`timescale 1ns/1ns
`default_nettype none

`include "dma_cfg.svh"

module tb_desc_fetch;

   localparam int MAX_REC = 64;

   logic        wb_clk = 1'b0;
   logic        wb_rst;
   logic        host_we;
   logic [1:0]  host_adr;
   logic [31:0] host_wdat;
   wire  [31:0] host_rdat;
   wire         cyc;
   wire         stb;
   wire         we;
   wire  [3:0]  sel;
   wire  [31:0] adr;
   wire  [31:0] wdat;
   logic [31:0] rdat = 32'h0;
   logic        ack = 1'b0;
   logic        err = 1'b0;
   logic [3:0]  c_done = 4'b0000;
   wire  [3:0]  ss_we;
   wire  [1:0]  ss_adr;
   wire  [31:0] ss_dat;
   wire  [1:0]  ss_done;
   wire         irq;
   logic        pre_we;
   logic [31:0] pre_adr;
   logic [31:0] pre_dat;
   logic        start;
   logic        fin;
   logic [31:0] ndar;
   logic [31:0] err_adr;
   logic [31:0] csr;
   logic [31:0] dar;
   logic [31:0] csr_clr;
   logic        case_active;
   wire  [31:0] n_pass;
   wire  [31:0] n_fail;
   logic [31:0] mem [0:255];
   logic [31:0] recs [0:3*MAX_REC-1];
   logic [1:0]  we_seen = 2'b00;
   logic [1:0]  dn_seen = 2'b00;
   integer      seed = 32'h4f74;
   int          wait_cnt = 0;
   int          cycles = 0;
   int          limit = 0;
   int          n_cases;
   int          bad_recs = 0;
   int          dly [0:1];

   always #20 wb_clk = ~wb_clk;

   desc_fetch_top i_dut (
      .wb_clk_i (wb_clk), .wb_rst_i (wb_rst),
      .host_we_i (host_we), .host_adr_i (host_adr), .host_dat_i (host_wdat),
      .host_dat_o (host_rdat),
      .wbm_cyc_o (cyc), .wbm_stb_o (stb), .wbm_we_o (we), .wbm_sel_o (sel),
      .wbm_adr_o (adr), .wbm_dat_o (wdat), .wbm_dat_i (rdat),
      .wbm_ack_i (ack), .wbm_err_i (err),
      .c_done_i (c_done),
      .ss_we_o (ss_we), .ss_adr_o (ss_adr), .ss_dat_o (ss_dat), .ss_done_o (ss_done),
      .wb_int_o (irq)
   );

   desc_checker i_chk (
      .wb_clk_i (wb_clk), .wb_rst_i (wb_rst),
      .pre_we_i (pre_we), .pre_adr_i (pre_adr), .pre_dat_i (pre_dat),
      .start_i (start), .ndar_i (ndar), .err_adr_i (err_adr),
      .end_i (fin), .csr_i (csr), .dar_i (dar), .csr_clr_i (csr_clr), .int_i (irq),
      .ss_we_i (ss_we), .ss_adr_i (ss_adr), .ss_dat_i (ss_dat), .ss_done_i (ss_done),
      .cyc_i (cyc), .stb_i (stb), .we_i (we), .ack_i (ack), .sel_i (sel),
      .adr_i (adr), .dat_i (wdat), .c_done_i (c_done),
      .pass_cnt_o (n_pass), .fail_cnt_o (n_fail)
   );

   // memory updates and event capture
   always @(posedge wb_clk) begin
      if (wb_rst) begin
         for (int i = 0; i < 256; i++) mem[i] <= 32'h0;
      end else begin
         if (pre_we) mem[pre_adr[9:2]] <= pre_dat;
         if (cyc && stb && we && ack) mem[adr[9:2]] <= wdat;
      end
      we_seen <= {ss_we[2], ss_we[0]};
      dn_seen <= ss_done;
      cycles  <= cycles + 1;
      if (limit > 0 && cycles >= limit) begin
         $display("timeout: run did not finish within %0d cycles", limit);
         $display("=== FAIL ===");
         $finish;
      end
   end

   // slave responses, 0 to 3 wait states per beat
   always @(negedge wb_clk) begin
      ack <= 1'b0;
      err <= 1'b0;
      if (!wb_rst && cyc && stb) begin
         if (wait_cnt > 0) begin
            wait_cnt--;
         end else begin
            if (!we && adr == err_adr) begin
               err <= 1'b1;
            end else begin
               ack  <= 1'b1;
               rdat <= mem[adr[9:2]];
            end
            wait_cnt = $random(seed) & 3;
         end
      end
   end

   // channel pairs report done some cycles after their slot loads
   always @(negedge wb_clk) begin
      for (int p = 0; p < 2; p++) begin
         if (!case_active || we_seen[p]) begin
            dly[p] = 0;
            c_done[2*p +: 2] <= 2'b00;
         end else if (dn_seen[p]) begin
            dly[p] = 20 * (p + 1); // longer than a burst, pair 1 lags pair 0
         end else if (dly[p] > 0) begin
            dly[p]--;
            if (dly[p] == 0) c_done[2*p +: 2] <= 2'b11;
         end
      end
   end

   task automatic preload(input logic [31:0] a, input logic [31:0] d);
      @(negedge wb_clk);
      pre_we  = 1'b1;
      pre_adr = a;
      pre_dat = d;
      @(negedge wb_clk);
      pre_we = 1'b0;
   endtask

   task automatic host_write(input logic [1:0] a, input logic [31:0] d);
      @(negedge wb_clk);
      host_we   = 1'b1;
      host_adr  = a;
      host_wdat = d;
      @(negedge wb_clk);
      host_we = 1'b0;
   endtask

   task automatic host_read(input logic [1:0] a, output logic [31:0] d);
      @(negedge wb_clk);
      host_adr = a;
      @(negedge wb_clk);
      d = host_rdat;
   endtask

   task automatic run_case(input logic [31:0] nd, input logic [31:0] ea);
      err_adr     = ea;
      case_active = 1'b1;
      @(negedge wb_clk);
      start = 1'b1;
      ndar  = nd;
      @(negedge wb_clk);
      start = 1'b0;
      host_write(`DMA_REG_NDAR, nd);
      while (!irq) @(negedge wb_clk);
   endtask

   task automatic close_case();
      host_read(`DMA_REG_CSR, csr);
      host_read(`DMA_REG_DAR, dar);
      host_write(`DMA_REG_CSR, 32'h4);   // clear interrupt and error
      host_read(`DMA_REG_CSR, csr_clr);
      case_active = 1'b0;
      @(negedge wb_clk);
      fin = 1'b1;
      @(negedge wb_clk);
      fin = 1'b0;
   endtask

   initial begin
      int i;
      host_we = 1'b0;
      host_adr = 2'd0;
      host_wdat = 32'h0;
      pre_we = 1'b0;
      pre_adr = 32'h0;
      pre_dat = 32'h0;
      start = 1'b0;
      fin = 1'b0;
      ndar = 32'h0;
      err_adr = 32'hffffffff;
      csr = 32'h0;
      dar = 32'h0;
      csr_clr = 32'h0;
      case_active = 1'b0;
      wb_rst = 1'b1;
      for (i = 0; i < 3 * MAX_REC; i++) recs[i] = 32'h0;
      $readmemh("verif/desc_cases.mem", recs);
      n_cases = 0;
      for (i = 0; i < MAX_REC; i++) if (recs[3*i] == 32'd2) n_cases++;
      limit = 600 * n_cases;
      repeat (2) @(negedge wb_clk);
      wb_rst = 1'b0;
      for (i = 0; i < MAX_REC && recs[3*i] != 32'd0; i++) begin
         case (recs[3*i])
            32'd1:   preload(recs[3*i+1], recs[3*i+2]);
            32'd2:   run_case(recs[3*i+1], recs[3*i+2]);
            32'd3:   close_case();
            default: begin
               $display("bad record kind %0h at record %0d", recs[3*i], i);
               bad_recs++;
            end
         endcase
      end
      repeat (2) @(negedge wb_clk);
      $display("cases passed %0d, failed %0d", n_pass, n_fail);
      if (n_fail == 32'd0 && n_pass == n_cases && bad_recs == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: verif/desc_checker.sv
// ==================================================
// descriptor engine checker: follows the chain in
// its own memory copy, compares slot loads, bus
// write-backs and final status, reports each case
// ==================================================
`timescale 1ns/1ns
`default_nettype none

module desc_checker (
   input  wire        wb_clk_i,
   input  wire        wb_rst_i,
   input  wire        pre_we_i,
   input  wire [31:0] pre_adr_i,
   input  wire [31:0] pre_dat_i,
   input  wire        start_i,
   input  wire [31:0] ndar_i,
   input  wire [31:0] err_adr_i,
   input  wire        end_i,
   input  wire [31:0] csr_i,
   input  wire [31:0] dar_i,
   input  wire [31:0] csr_clr_i,
   input  wire        int_i,
   input  wire [3:0]  ss_we_i,
   input  wire [1:0]  ss_adr_i,
   input  wire [31:0] ss_dat_i,
   input  wire [1:0]  ss_done_i,
   input  wire        cyc_i,
   input  wire        stb_i,
   input  wire        we_i,
   input  wire        ack_i,
   input  wire [3:0]  sel_i,
   input  wire [31:0] adr_i,
   input  wire [31:0] dat_i,
   input  wire [3:0]  c_done_i,
   output logic [31:0] pass_cnt_o,
   output logic [31:0] fail_cnt_o
);

   logic [31:0] mem [0:255];
   logic [31:0] wb_dat [0:255];   // expected write-back words
   logic        wb_val [0:255];
   logic        wb_slot [0:255];
   logic [34:0] ld_q [$];         // {slot, idx, word}
   logic        dn_q [$];
   logic [34:0] rec;
   logic [31:0] exp_dar;
   logic [7:0]  w;
   logic        exp_err;
   logic        bad;
   int          wb_left;
   int          case_no;

   task automatic report_mismatch(input string msg);
      $display("ERROR at %0t: case %0d %s", $time, case_no, msg);
      bad = 1'b1;
   endtask

   task automatic report_missing(input string msg);
      $display("case %0d failed: %s", case_no, msg);
      bad = 1'b1;
   endtask

   // walk the chain the way the engine should
   task automatic expect_chain(input logic [31:0] ndar, input logic [31:0] err_adr);
      logic [7:0] a;
      logic [7:0] wa;
      logic       slot;
      logic       hit;
      int         n;
      int         i;
      a = ndar[9:2];
      slot = 1'b0;
      hit = 1'b0;
      ld_q.delete();
      dn_q.delete();
      wb_left = 0;
      for (i = 0; i < 256; i++) wb_val[i] = 1'b0;
      for (n = 0; n < 6; n++) begin
         exp_dar = {22'd0, a, 2'b00};
         for (i = 0; i < 4 && !hit; i++) begin
            wa = a + 8'(i);
            if ({22'd0, wa, 2'b00} == err_adr) hit = 1'b1;
            else ld_q.push_back({slot, 2'(i), mem[wa]});
         end
         if (hit) break;
         dn_q.push_back(slot);
         if (mem[a][7]) begin          // write-back requested
            for (i = 0; i < 4; i++) begin
               wa = a + 8'(i);
               wb_val[wa] = 1'b1;
               wb_slot[wa] = slot;
               wb_dat[wa] = mem[wa] | ((i == 0) ? 32'h80000000 : 32'h0);
            end
            wb_left = wb_left + 4;
         end
         if (!mem[a][14]) break;       // end of chain
         wa = a + 8'd1;
         a = {mem[wa][9:3], 1'b0};
         slot = ~slot;
      end
      exp_err = hit;
      if (hit) begin                   // abort cancels all write-backs
         for (i = 0; i < 256; i++) wb_val[i] = 1'b0;
         wb_left = 0;
      end
   endtask

   always @(posedge wb_clk_i) begin
      if (wb_rst_i) begin
         for (int i = 0; i < 256; i++) mem[i] = 32'h0;
         pass_cnt_o = 32'd0;
         fail_cnt_o = 32'd0;
         case_no = 0;
         bad = 1'b0;
      end else begin
         if (pre_we_i) mem[pre_adr_i[9:2]] = pre_dat_i;
         if (start_i) begin
            case_no = case_no + 1;
            expect_chain(ndar_i, err_adr_i);
         end
         if (|ss_we_i) begin
            if (ld_q.size() == 0) begin
               report_mismatch($sformatf("unexpected slot write %h", ss_dat_i));
            end else begin
               rec = ld_q.pop_front();
               if (ss_we_i != (rec[34] ? 4'b1100 : 4'b0011) || ss_adr_i != rec[33:32] ||
                   ss_dat_i != rec[31:0]) begin
                  report_mismatch($sformatf("slot %0d word %0d got we %b %h, expected %h",
                     rec[34], rec[33:32], ss_we_i, ss_dat_i, rec[31:0]));
               end
            end
         end
         if (|ss_done_i) begin
            if (dn_q.size() == 0) report_mismatch("unexpected slot loaded pulse");
            else if (ss_done_i != (dn_q.pop_front() ? 2'b10 : 2'b01))
               report_mismatch($sformatf("slot loaded pulse %b on wrong pair", ss_done_i));
         end
         if (cyc_i && sel_i != 4'hf) report_mismatch($sformatf("sel %h", sel_i));
         if (cyc_i && stb_i && we_i && ack_i) begin
            w = adr_i[9:2];
            if (!wb_val[w]) begin
               report_mismatch($sformatf("write to %h not expected", adr_i));
            end else begin
               wb_val[w] = 1'b0;
               wb_left = wb_left - 1;
               if (dat_i != wb_dat[w])
                  report_mismatch($sformatf("write-back %h got %h, expected %h",
                     adr_i, dat_i, wb_dat[w]));
               if (c_done_i[int'(wb_slot[w]) * 2 +: 2] != 2'b11)
                  report_mismatch($sformatf("write-back %h before channels done", adr_i));
            end
         end
         if (end_i) begin
            if (ld_q.size() != 0) report_missing("slot words were never loaded");
            if (dn_q.size() != 0) report_missing("slot loaded pulse never came");
            if (wb_left != 0) report_missing("write-back words were never written");
            if (csr_i[2:0] != {1'b1, exp_err, 1'b0})
               report_mismatch($sformatf("status %b, expected %b", csr_i[2:0],
                  {1'b1, exp_err, 1'b0}));
            if (dar_i != exp_dar)
               report_mismatch($sformatf("DAR %h, expected %h", dar_i, exp_dar));
            if (int_i || csr_clr_i[2:1] != 2'b00)
               report_mismatch("interrupt or error flag still set after clear");
            if (bad) begin
               fail_cnt_o = fail_cnt_o + 32'd1;
               $display("case %0d failed", case_no);
            end else begin
               pass_cnt_o = pass_cnt_o + 32'd1;
               $display("case %0d passed", case_no);
            end
            bad = 1'b0;
         end
      end
   end

endmodule

`default_nettype wire

// File: rtl/desc_fetch_top.sv
// ==================================================
// descriptor fetch engine top: FSM, slot store,
// burst address, host registers, wishbone master
// ==================================================
`timescale 1ns/1ns
`default_nettype none

`include "dma_cfg.svh"

module desc_fetch_top (
   input  wire                  wb_clk_i,
   input  wire                  wb_rst_i,
   input  wire                  host_we_i,
   input  wire [1:0]            host_adr_i,
   input  wire [`DMA_DW-1:0]    host_dat_i,
   output logic [`DMA_DW-1:0]   host_dat_o,
   output logic                 wbm_cyc_o,
   output logic                 wbm_stb_o,
   output logic                 wbm_we_o,
   output logic [`DMA_DW/8-1:0] wbm_sel_o,
   output logic [`DMA_AW-1:0]   wbm_adr_o,
   output logic [`DMA_DW-1:0]   wbm_dat_o,
   input  wire [`DMA_DW-1:0]    wbm_dat_i,
   input  wire                  wbm_ack_i,
   input  wire                  wbm_err_i,
   input  wire [3:0]            c_done_i,
   output logic [3:0]           ss_we_o,
   output logic [1:0]           ss_adr_o,
   output logic [`DMA_DW-1:0]   ss_dat_o,
   output logic [1:0]           ss_done_o,
   output logic                 wb_int_o
);

   dma_pkg::wb_req_t         ctrl_bus;
   dma_pkg::wb_req_t         wbm_req;
   dma_pkg::wb_rsp_t         wbm_rsp;
   dma_pkg::slot_wr_t        slot_wr;
   dma_pkg::desc_adr_t       ndar;
   dma_pkg::desc_adr_t       load_adr;
   dma_pkg::desc_adr_t [1:0] next_adr;
   dma_pkg::beat_t           beat;
   dma_pkg::dma_word_t       wb_dat;
   logic [`DMA_AW-1:0]       burst_adr;
   logic [1:0] chain;
   logic [1:0] wb_req;
   logic ndar_dirty;
   logic load;
   logic step;
   logic fetch_start;
   logic dar_load;
   logic chain_end;
   logic bus_fault;
   logic busy;

   assign wbm_rsp = '{dat: wbm_dat_i, ack: wbm_ack_i, err: wbm_err_i};
   assign wbm_req = '{cyc: ctrl_bus.cyc, stb: ctrl_bus.stb, we: ctrl_bus.we,
                      adr: burst_adr, dat: wb_dat, sel: ctrl_bus.sel};

   assign wbm_cyc_o = wbm_req.cyc;
   assign wbm_stb_o = wbm_req.stb;
   assign wbm_we_o  = wbm_req.we;
   assign wbm_sel_o = wbm_req.sel;
   assign wbm_adr_o = wbm_req.adr;
   assign wbm_dat_o = wbm_req.dat;

   desc_ctrl i_ctrl (
      .wb_clk_i, .wb_rst_i,
      .ndar_dirty_i (ndar_dirty), .ndar_i (ndar), .rsp_i (wbm_rsp), .beat_i (beat),
      .chain_i (chain), .wb_req_i (wb_req), .next_i (next_adr), .c_done_i,
      .bus_o (ctrl_bus), .load_o (load), .load_adr_o (load_adr), .step_o (step),
      .slot_wr_o (slot_wr), .fetch_start_o (fetch_start), .dar_load_o (dar_load),
      .chain_end_o (chain_end), .bus_fault_o (bus_fault), .busy_o (busy)
   );

   desc_store i_store (
      .wb_clk_i, .wb_rst_i,
      .slot_wr_i (slot_wr), .wb_slot_i (slot_wr.slot), .beat_i (beat),
      .ss_we_o, .ss_adr_o, .ss_dat_o, .ss_done_o,
      .chain_o (chain), .wb_req_o (wb_req), .next_o (next_adr), .wb_dat_o (wb_dat)
   );

   burst_addr i_addr (
      .wb_clk_i, .wb_rst_i,
      .load_i (load), .load_adr_i (load_adr), .step_i (step),
      .adr_o (burst_adr), .beat_o (beat)
   );

   dma_csr i_csr (
      .wb_clk_i, .wb_rst_i,
      .host_we_i, .host_adr_i, .host_dat_i,
      .fetch_start_i (fetch_start), .dar_load_i (dar_load), .load_adr_i (load_adr),
      .chain_end_i (chain_end), .bus_fault_i (bus_fault), .busy_i (busy),
      .host_dat_o, .ndar_o (ndar), .ndar_dirty_o (ndar_dirty), .wb_int_o
   );

endmodule

`default_nettype wire

// File: rtl/desc_ctrl.sv
// ==================================================
// descriptor engine FSM: fetch, channel wait,
// write-back and chaining over wishbone bursts
// ==================================================
`timescale 1ns/1ns
`default_nettype none

`include "dma_cfg.svh"

module desc_ctrl (
   input  wire                            wb_clk_i,
   input  wire                            wb_rst_i,
   input  wire                            ndar_dirty_i,
   input  wire dma_pkg::desc_adr_t        ndar_i,
   input  wire dma_pkg::wb_rsp_t          rsp_i,
   input  wire dma_pkg::beat_t            beat_i,
   input  wire [1:0]                      chain_i,
   input  wire [1:0]                      wb_req_i,
   input  wire dma_pkg::desc_adr_t [1:0]  next_i,
   input  wire [3:0]                      c_done_i,
   output dma_pkg::wb_req_t               bus_o,
   output logic                           load_o,
   output dma_pkg::desc_adr_t             load_adr_o,
   output logic                           step_o,
   output dma_pkg::slot_wr_t              slot_wr_o,
   output logic                           fetch_start_o,
   output logic                           dar_load_o,
   output logic                           chain_end_o,
   output logic                           bus_fault_o,
   output logic                           busy_o
);

   localparam dma_pkg::beat_t LAST_BEAT = dma_pkg::beat_t'(`DMA_BEATS - 1);

   dma_pkg::ctrl_state_t state_q;
   dma_pkg::ctrl_state_t state_d;
   dma_pkg::desc_adr_t [1:0] cdar_q; // address each slot came from
   logic cyc_q;
   logic stb_q;
   logic we_q;
   logic bus_on;
   logic bus_off;
   logic in_burst;
   logic fetching;
   logic beat_last;

   assign fetching  = (state_q == dma_pkg::ST_FETCH0) || (state_q == dma_pkg::ST_FETCH1);
   assign in_burst  = fetching || (state_q == dma_pkg::ST_WB0) ||
                      (state_q == dma_pkg::ST_WB1);
   assign step_o    = in_burst && rsp_i.ack && !rsp_i.err; // retry is just a wait
   assign beat_last = step_o && (beat_i == LAST_BEAT);
   assign bus_off   = in_burst && (rsp_i.err || beat_last);

   always_comb begin
      state_d       = state_q;
      bus_on        = 1'b0;
      load_o        = 1'b0;
      load_adr_o    = ndar_i;
      fetch_start_o = 1'b0;
      dar_load_o    = 1'b0;
      chain_end_o   = 1'b0;
      case (state_q)
         dma_pkg::ST_IDLE: begin
            if (ndar_dirty_i) begin
               load_o        = 1'b1;
               fetch_start_o = 1'b1;
               dar_load_o    = 1'b1;
               bus_on        = 1'b1;
               state_d       = dma_pkg::ST_FETCH0;
            end
         end
         dma_pkg::ST_FETCH0: if (beat_last) state_d = dma_pkg::ST_NEXT0;
         dma_pkg::ST_NEXT0: begin
            if (chain_i[0]) begin           // second descriptor for ch 2/3
               load_o     = 1'b1;
               load_adr_o = next_i[0];
               dar_load_o = 1'b1;
               bus_on     = 1'b1;
               state_d    = dma_pkg::ST_FETCH1;
            end else begin
               state_d = dma_pkg::ST_WAIT0;
            end
         end
         dma_pkg::ST_FETCH1: if (beat_last) state_d = dma_pkg::ST_WAIT0;
         dma_pkg::ST_WAIT0: begin
            if (&c_done_i[1:0]) begin
               if (wb_req_i[0]) begin
                  load_o     = 1'b1;
                  load_adr_o = cdar_q[0];
                  bus_on     = 1'b1;
                  state_d    = dma_pkg::ST_WB0;
               end else if (chain_i[0]) begin
                  state_d = dma_pkg::ST_WAIT1;
               end else begin
                  chain_end_o = 1'b1;
                  state_d     = dma_pkg::ST_IDLE;
               end
            end
         end
         dma_pkg::ST_WB0: begin
            if (beat_last) begin
               if (chain_i[0]) begin
                  state_d = dma_pkg::ST_WAIT1;
               end else begin
                  chain_end_o = 1'b1;
                  state_d     = dma_pkg::ST_IDLE;
               end
            end
         end
         dma_pkg::ST_WAIT1: begin
            if (&c_done_i[3:2]) begin
               if (wb_req_i[1]) begin
                  load_o     = 1'b1;
                  load_adr_o = cdar_q[1];
                  bus_on     = 1'b1;
                  state_d    = dma_pkg::ST_WB1;
               end else begin
                  state_d = dma_pkg::ST_NEXT1;
               end
            end
         end
         dma_pkg::ST_WB1: if (beat_last) state_d = dma_pkg::ST_NEXT1;
         dma_pkg::ST_NEXT1: begin
            if (chain_i[1]) begin           // wrap back into slot 0
               load_o     = 1'b1;
               load_adr_o = next_i[1];
               dar_load_o = 1'b1;
               bus_on     = 1'b1;
               state_d    = dma_pkg::ST_FETCH0;
            end else begin
               chain_end_o = 1'b1;
               state_d     = dma_pkg::ST_IDLE;
            end
         end
         default: state_d = dma_pkg::ST_IDLE;
      endcase
      if (in_burst && rsp_i.err) begin
         state_d = dma_pkg::ST_IDLE; // abort, no further slots
      end
   end

   assign bus_fault_o = in_burst && rsp_i.err;

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         state_q <= dma_pkg::ST_IDLE;
         cyc_q   <= 1'b0;
         stb_q   <= 1'b0;
         we_q    <= 1'b0;
      end else begin
         state_q <= state_d;
         if (bus_on) begin
            cyc_q <= 1'b1;
            stb_q <= 1'b1;
            we_q  <= (state_q == dma_pkg::ST_WAIT0) || (state_q == dma_pkg::ST_WAIT1);
         end else if (bus_off) begin
            cyc_q <= 1'b0;
            stb_q <= 1'b0;
            we_q  <= 1'b0;
         end
      end
   end

   always_ff @(posedge wb_clk_i) begin
      if (dar_load_o) begin
         cdar_q[state_q == dma_pkg::ST_NEXT0] <= load_adr_o; // only NEXT0 fills slot 1
      end
   end

   assign bus_o.cyc = cyc_q;
   assign bus_o.stb = stb_q;
   assign bus_o.we  = we_q;
   assign bus_o.adr = '0;
   assign bus_o.dat = '0;
   assign bus_o.sel = '1;

   assign slot_wr_o.slot = (state_q == dma_pkg::ST_FETCH1) || (state_q == dma_pkg::ST_WAIT1) ||
                           (state_q == dma_pkg::ST_WB1);
   assign slot_wr_o.idx  = beat_i;
   assign slot_wr_o.dat  = rsp_i.dat;
   assign slot_wr_o.we   = step_o && fetching;

   assign busy_o = (state_q != dma_pkg::ST_IDLE);

   a_stb_cyc : assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      stb_q |-> cyc_q && in_burst);

   a_fetch_rd : assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      fetching |-> !we_q);

endmodule

`default_nettype wire

// File: rtl/dma_csr.sv
// ==================================================
// host registers: NDAR with dirty flag, DAR,
// status, error flag and pending interrupt
// ==================================================
`timescale 1ns/1ns
`default_nettype none

`include "dma_cfg.svh"

module dma_csr (
   input  wire                      wb_clk_i,
   input  wire                      wb_rst_i,
   input  wire                      host_we_i,
   input  wire [1:0]                host_adr_i,
   input  wire dma_pkg::dma_word_t  host_dat_i,
   input  wire                      fetch_start_i,
   input  wire                      dar_load_i,
   input  wire dma_pkg::desc_adr_t  load_adr_i,
   input  wire                      chain_end_i,
   input  wire                      bus_fault_i,
   input  wire                      busy_i,
   output dma_pkg::dma_word_t       host_dat_o,
   output dma_pkg::desc_adr_t       ndar_o,
   output logic                     ndar_dirty_o,
   output logic                     wb_int_o
);

   dma_pkg::desc_adr_t ndar_q;
   dma_pkg::desc_adr_t dar_q;
   logic dirty_q;
   logic err_q;
   logic int_q;
   logic wr_ndar;
   logic int_clr;

   assign wr_ndar = host_we_i && (host_adr_i == `DMA_REG_NDAR);
   assign int_clr = host_we_i && (host_adr_i == `DMA_REG_CSR) && host_dat_i[2];

   always_ff @(posedge wb_clk_i) begin
      if (wr_ndar) ndar_q <= host_dat_i[`DMA_AW-1:3];
      if (dar_load_i) dar_q <= load_adr_i;
   end

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         dirty_q <= 1'b0;
         err_q   <= 1'b0;
         int_q   <= 1'b0;
      end else begin
         if (wr_ndar) dirty_q <= 1'b1;          // a new write wins over the clear
         else if (fetch_start_i) dirty_q <= 1'b0;
         if (bus_fault_i) err_q <= 1'b1;
         else if (int_clr) err_q <= 1'b0;
         if (chain_end_i || bus_fault_i) int_q <= 1'b1;
         else if (int_clr) int_q <= 1'b0;
      end
   end

   always_comb begin
      case (host_adr_i)
         `DMA_REG_NDAR: host_dat_o = {ndar_q, 3'b000};
         `DMA_REG_CSR:  host_dat_o = {{(`DMA_DW-3){1'b0}}, int_q, err_q, busy_i};
         `DMA_REG_DAR:  host_dat_o = {dar_q, 3'b000};
         default:       host_dat_o = '0;
      endcase
   end

   assign ndar_o       = ndar_q;
   assign ndar_dirty_o = dirty_q;
   assign wb_int_o     = int_q;

endmodule

`default_nettype wire

// File: rtl/desc_store.sv
// ==================================================
// two four-word descriptor slots, decoded chain,
// write-back and next fields, write-back data
// ==================================================
`timescale 1ns/1ns
`default_nettype none

`include "dma_cfg.svh"

module desc_store (
   input  wire                            wb_clk_i,
   input  wire                            wb_rst_i,
   input  wire dma_pkg::slot_wr_t         slot_wr_i,
   input  wire                            wb_slot_i,
   input  wire dma_pkg::beat_t            beat_i,
   output logic [3:0]                     ss_we_o,
   output dma_pkg::beat_t                 ss_adr_o,
   output dma_pkg::dma_word_t             ss_dat_o,
   output logic [1:0]                     ss_done_o,
   output logic [1:0]                     chain_o,
   output logic [1:0]                     wb_req_o,
   output dma_pkg::desc_adr_t [1:0]       next_o,
   output dma_pkg::dma_word_t             wb_dat_o
);

   localparam dma_pkg::beat_t LAST_BEAT = dma_pkg::beat_t'(`DMA_BEATS - 1);

   dma_pkg::dma_word_t mem_q [0:1][0:`DMA_BEATS-1];
   logic [1:0] done_q;

   always_ff @(posedge wb_clk_i) begin
      if (slot_wr_i.we) begin
         mem_q[slot_wr_i.slot][slot_wr_i.idx] <= slot_wr_i.dat;
      end
   end

   // loaded pulse one cycle after word 3 lands
   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         done_q <= 2'b00;
      end else begin
         done_q <= 2'b00;
         if (slot_wr_i.we && (slot_wr_i.idx == LAST_BEAT)) begin
            done_q[slot_wr_i.slot] <= 1'b1;
         end
      end
   end

   assign ss_we_o   = {{2{slot_wr_i.we & slot_wr_i.slot}}, {2{slot_wr_i.we & ~slot_wr_i.slot}}};
   assign ss_adr_o  = slot_wr_i.idx;
   assign ss_dat_o  = slot_wr_i.dat;
   assign ss_done_o = done_q;

   for (genvar s = 0; s < 2; s++) begin : g_slot
      assign chain_o[s]  = mem_q[s][0][`DMA_CHAIN_BIT];
      assign wb_req_o[s] = mem_q[s][0][`DMA_WB_BIT];
      assign next_o[s]   = mem_q[s][1][`DMA_AW-1:3]; // word 1 is the chain pointer
   end

   always_comb begin
      wb_dat_o = mem_q[wb_slot_i][beat_i];
      if (beat_i == '0) begin
         wb_dat_o[`DMA_DONE_BIT] = 1'b1; // mark descriptor done
      end
   end

endmodule

`default_nettype wire

// File: rtl/burst_addr.sv
// ==================================================
// burst address register and beat counter
// ==================================================
`timescale 1ns/1ns
`default_nettype none

`include "dma_cfg.svh"

module burst_addr (
   input  wire                      wb_clk_i,
   input  wire                      wb_rst_i,
   input  wire                      load_i,
   input  wire dma_pkg::desc_adr_t  load_adr_i,
   input  wire                      step_i,
   output logic [`DMA_AW-1:0]       adr_o,
   output dma_pkg::beat_t           beat_o
);

   logic [`DMA_AW-1:2] wadr_q; // word address
   dma_pkg::beat_t     beat_q;

   always_ff @(posedge wb_clk_i) begin
      if (load_i) begin
         wadr_q <= {load_adr_i, 1'b0};
      end else if (step_i) begin
         wadr_q <= wadr_q + 1'b1;
      end
   end

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         beat_q <= '0;
      end else if (load_i) begin
         beat_q <= '0;
      end else if (step_i) begin
         beat_q <= beat_q + 1'b1;
      end
   end

   assign adr_o  = {wadr_q, 2'b00};
   assign beat_o = beat_q;

   a_no_step_on_load : assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      !(load_i && step_i));

endmodule

`default_nettype wire

// File: rtl/dma_pkg.sv
// ==================================================
// word and address types, wishbone request and
// response structs, slot write struct, FSM states
// ==================================================
`default_nettype none

`include "dma_cfg.svh"

package dma_pkg;

   typedef logic [`DMA_DW-1:0]              dma_word_t;
   typedef logic [`DMA_AW-1:3]              desc_adr_t; // 8-byte aligned
   typedef logic [$clog2(`DMA_BEATS)-1:0]   beat_t;

   typedef struct packed {
      logic                 cyc;
      logic                 stb;
      logic                 we;
      logic [`DMA_AW-1:0]   adr;
      dma_word_t            dat;
      logic [`DMA_DW/8-1:0] sel;
   } wb_req_t;

   typedef struct packed {
      dma_word_t dat;
      logic      ack;
      logic      err;
   } wb_rsp_t;

   typedef struct packed {
      logic      slot; // 0 feeds ch 0/1, 1 feeds ch 2/3
      beat_t     idx;
      dma_word_t dat;
      logic      we;
   } slot_wr_t;

   typedef enum logic [3:0] {
      ST_IDLE,
      ST_FETCH0,
      ST_NEXT0,
      ST_FETCH1,
      ST_WAIT0,
      ST_WB0,
      ST_WAIT1,
      ST_WB1,
      ST_NEXT1
   } ctrl_state_t;

endpackage

`default_nettype wire

// File: rtl/dma_cfg.svh
// ==================================================
// bus widths, descriptor layout and control bits
// host register map of the descriptor fetch engine
// ==================================================
`ifndef DMA_CFG_SVH
`define DMA_CFG_SVH

`define DMA_DW        32   // wishbone data width
`define DMA_AW        32   // wishbone address width
`define DMA_BEATS     4    // words per descriptor

`define DMA_CHAIN_BIT 14   // word 0, next descriptor follows
`define DMA_WB_BIT    7    // word 0, write descriptor back
`define DMA_DONE_BIT  31   // word 0, set on write-back

`define DMA_REG_NDAR  2'd0 // next descriptor address
`define DMA_REG_CSR   2'd1 // status and interrupt
`define DMA_REG_DAR   2'd2 // last fetched descriptor

`endif
